/* compile.f */
hw/core_cfg_pkg.sv
hw/isa_pkg.sv
hw/alu_mul_lane.sv
hw/alu_div_lane.sv
hw/reg_writeback.sv
hw/dual_issue_core.sv
tests/dual_issue_core_assert.sv
tests/tb_dual_issue_core.sv

/* Bender.yml */
package:
  name: dual_issue_core

sources:
  - files:
      - hw/core_cfg_pkg.sv
      - hw/isa_pkg.sv
      - hw/alu_mul_lane.sv
      - hw/alu_div_lane.sv
      - hw/reg_writeback.sv
      - hw/dual_issue_core.sv
  - target: test
    files:
      - tests/dual_issue_core_assert.sv
      - tests/tb_dual_issue_core.sv

/* tests/tb_dual_issue_core.sv */
module tb_dual_issue_core;
    import core_cfg_pkg::*;
    import isa_pkg::*;

    localparam int CLK_PERIOD = 20;
    localparam int NUM_DIRECTED = 8;
    localparam int NUM_RANDOM = 300;
    localparam int NUM_PAIRS = NUM_DIRECTED + NUM_RANDOM;

    logic clk;
    logic rstn;
    logic issue_valid;
    opcode_t op0;
    opcode_t op1;
    reg_addr_t rd0;
    reg_addr_t rj0;
    reg_addr_t rk0;
    reg_addr_t rd1;
    reg_addr_t rj1;
    reg_addr_t rk1;
    word_t imm0;
    word_t imm1;
    logic use_imm0;
    logic use_imm1;
    logic issue_ready;
    logic wb_valid;
    logic wb0_we;
    logic wb1_we;
    reg_addr_t wb0_rd;
    reg_addr_t wb1_rd;
    word_t wb0_data;
    word_t wb1_data;

    // reference register file and the pair in flight
    word_t model_regs [NUM_REGS];
    logic pending;
    logic exp_we0;
    logic exp_we1;
    reg_addr_t exp_rd0;
    reg_addr_t exp_rd1;
    word_t exp_data0;
    word_t exp_data1;
    int accept_cnt;
    int wb_cnt;
    integer seed;

    dual_issue_core #(
        .DIV_STEPS (2)
    ) dut0 (.*);

    always #(CLK_PERIOD / 2) clk = ~clk;

    task automatic stop_with_failure();
        $display("Some tests failed");
        $fatal(1);
    endtask

    task automatic check_word(input string name, input word_t got, input word_t exp);
        if (got !== exp) begin
            $display("[ERROR] %s: got 0x%h, expected 0x%h", name, got, exp);
            stop_with_failure();
        end
    endtask

    task automatic check_reg_addr(input string name, input reg_addr_t got, input reg_addr_t exp);
        if (got !== exp) begin
            $display("[ERROR] %s: got 0x%h, expected 0x%h", name, got, exp);
            stop_with_failure();
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("[ERROR] %s: got 0x%h, expected 0x%h", name, got, exp);
            stop_with_failure();
        end
    endtask

    function automatic word_t model_result(opcode_t op, word_t a, word_t b);
        logic overflow;
        overflow = (a == (word_t'(1) << (XLEN - 1))) && (b == '1);
        case (op)
            op_add:  return a + b;
            op_sub:  return a - b;
            op_and:  return a & b;
            op_or:   return a | b;
            op_xor:  return a ^ b;
            op_slt:  return ($signed(a) < $signed(b)) ? word_t'(1) : '0;
            op_sltu: return (a < b) ? word_t'(1) : '0;
            op_sll:  return a << b[4:0];
            op_srl:  return a >> b[4:0];
            op_sra:  return $signed(a) >>> b[4:0];
            op_mul:  return a * b;
            op_div: begin
                if (b == '0) return '1;
                if (overflow) return a;
                return $signed(a) / $signed(b);
            end
            op_divu: begin
                if (b == '0) return '1;
                return a / b;
            end
            op_mod: begin
                if (b == '0) return a;
                if (overflow) return '0;
                return $signed(a) % $signed(b);
            end
            op_modu: begin
                if (b == '0) return a;
                return a % b;
            end
            default: return '0;
        endcase
    endfunction

    function automatic word_t operand_b(reg_addr_t rk, word_t imm, logic use_imm);
        return use_imm ? imm : model_regs[rk];
    endfunction

    // corner values show up often enough to hit the division rules
    function automatic word_t random_word();
        case ($unsigned($random(seed)) % 8)
            0: return '0;
            1: return '1;
            2: return word_t'(1) << (XLEN - 1);
            3: return ~(word_t'(1) << (XLEN - 1));
            4: return word_t'(1);
            default: return $random(seed);
        endcase
    endfunction

    // a small register window makes rd collisions common
    function automatic reg_addr_t random_reg();
        return reg_addr_t'($unsigned($random(seed)) % 8);
    endfunction

    task automatic issue_pair(input opcode_t o0, input reg_addr_t d0, input reg_addr_t j0,
                              input reg_addr_t k0, input word_t i0, input logic u0,
                              input opcode_t o1, input reg_addr_t d1, input reg_addr_t j1,
                              input reg_addr_t k1, input word_t i1, input logic u1);
        int gap;
        gap = $unsigned($random(seed)) % 4;
        repeat (gap) begin
            @(negedge clk);
            issue_valid = 1'b0;
        end
        @(negedge clk);
        op0 = o0;
        rd0 = d0;
        rj0 = j0;
        rk0 = k0;
        imm0 = i0;
        use_imm0 = u0;
        op1 = o1;
        rd1 = d1;
        rj1 = j1;
        rk1 = k1;
        imm1 = i1;
        use_imm1 = u1;
        issue_valid = 1'b1;
        while (!issue_ready) begin
            @(negedge clk);
        end
        // accepted on the next rising edge so the sources are still the pre-pair values
        exp_we0 = (d0 != '0);
        exp_rd0 = d0;
        exp_data0 = model_result(o0, model_regs[j0], operand_b(k0, i0, u0));
        exp_we1 = (d1 != '0);
        exp_rd1 = d1;
        exp_data1 = model_result(o1, model_regs[j1], operand_b(k1, i1, u1));
        pending = 1'b1;
        accept_cnt++;
    endtask

    task automatic random_pair();
        int sel;
        opcode_t o0;
        opcode_t o1;
        word_t i0;
        word_t i1;
        reg_addr_t d0;
        reg_addr_t j0;
        reg_addr_t k0;
        reg_addr_t d1;
        reg_addr_t j1;
        reg_addr_t k1;
        logic u0;
        logic u1;
        sel = $unsigned($random(seed)) % 11;
        o0 = opcode_t'(sel);
        // lane 1 has no multiplier so op_mul is skipped
        sel = $unsigned($random(seed)) % 14;
        o1 = opcode_t'((sel < 10) ? sel : sel + 1);
        d0 = random_reg();
        j0 = random_reg();
        k0 = random_reg();
        d1 = random_reg();
        j1 = random_reg();
        k1 = random_reg();
        i0 = random_word();
        i1 = random_word();
        u0 = ($random(seed) % 2) != 0;
        u1 = ($random(seed) % 2) != 0;
        issue_pair(o0, d0, j0, k0, i0, u0, o1, d1, j1, k1, i1, u1);
    endtask

    always @(negedge clk) begin
        if (rstn && wb_valid) begin
            if (!pending) begin
                $display("write-back seen with no accepted pair in flight");
                stop_with_failure();
            end
            check_bit("wb0_we", wb0_we, exp_we0);
            check_reg_addr("wb0_rd", wb0_rd, exp_rd0);
            check_word("wb0_data", wb0_data, exp_data0);
            check_bit("wb1_we", wb1_we, exp_we1);
            check_reg_addr("wb1_rd", wb1_rd, exp_rd1);
            check_word("wb1_data", wb1_data, exp_data1);
            // lane 1 written last
            if (exp_we0) begin
                model_regs[exp_rd0] = exp_data0;
            end
            if (exp_we1) begin
                model_regs[exp_rd1] = exp_data1;
            end
            pending = 1'b0;
            wb_cnt++;
        end
    end

    initial begin
        #(NUM_PAIRS * (XLEN + 6) * CLK_PERIOD);
        $display("timed out waiting for the issued pairs to write back");
        stop_with_failure();
    end

    initial begin
        seed = 19685;
        clk = 1'b0;
        rstn = 1'b0;
        issue_valid = 1'b0;
        op0 = op_add;
        op1 = op_add;
        rd0 = '0;
        rj0 = '0;
        rk0 = '0;
        rd1 = '0;
        rj1 = '0;
        rk1 = '0;
        imm0 = '0;
        imm1 = '0;
        use_imm0 = 1'b0;
        use_imm1 = 1'b0;
        pending = 1'b0;
        accept_cnt = 0;
        wb_cnt = 0;
        for (int i = 0; i < NUM_REGS; i++) begin
            model_regs[i] = '0;
        end
        repeat (4) @(posedge clk);
        @(negedge clk);
        rstn = 1'b1;
        check_bit("issue_ready", issue_ready, 1'b1);
        check_bit("wb_valid", wb_valid, 1'b0);
        check_bit("wb0_we", wb0_we, 1'b0);
        check_bit("wb1_we", wb1_we, 1'b0);
        check_bit("done0", dut0.done0, 1'b0);
        check_bit("done1", dut0.done1, 1'b0);

        // first pair reads an all-zero register file
        issue_pair(op_add, 5'd1, 5'd3, 5'd0, 32'h8000_0000, 1'b1,
                   op_add, 5'd2, 5'd4, 5'd0, 32'hffff_ffff, 1'b1);
        // most negative by minus one
        issue_pair(op_mul, 5'd3, 5'd1, 5'd2, 32'h0, 1'b0,
                   op_div, 5'd4, 5'd1, 5'd2, 32'h0, 1'b0);
        issue_pair(op_sub, 5'd5, 5'd1, 5'd0, 32'h1, 1'b1,
                   op_mod, 5'd6, 5'd1, 5'd2, 32'h0, 1'b0);
        // divide by zero with lane 0 aimed at r0
        issue_pair(op_xor, 5'd0, 5'd1, 5'd2, 32'h0, 1'b0,
                   op_div, 5'd7, 5'd1, 5'd0, 32'h0, 1'b1);
        issue_pair(op_srl, 5'd3, 5'd2, 5'd0, 32'h4, 1'b1,
                   op_modu, 5'd7, 5'd5, 5'd0, 32'h0, 1'b1);
        // both lanes on r6
        issue_pair(op_or, 5'd6, 5'd1, 5'd0, 32'h5, 1'b1,
                   op_and, 5'd6, 5'd2, 5'd0, 32'hff, 1'b1);
        // lane 1 reads r1 while lane 0 rewrites it
        issue_pair(op_add, 5'd1, 5'd6, 5'd0, 32'h1, 1'b1,
                   op_divu, 5'd2, 5'd1, 5'd6, 32'h0, 1'b0);
        issue_pair(op_add, 5'd5, 5'd0, 5'd0, 32'h0, 1'b0,
                   op_divu, 5'd0, 5'd1, 5'd0, 32'h3, 1'b1);

        for (int n = 0; n < NUM_RANDOM; n++) begin
            random_pair();
        end
        @(negedge clk);
        issue_valid = 1'b0;
        while (pending) begin
            @(negedge clk);
        end

        if (accept_cnt != wb_cnt) begin
            $display("accepted %0d pairs but saw %0d write-backs", accept_cnt, wb_cnt);
            stop_with_failure();
        end else if (dut0.u_proto_chk.fail_cnt != 0) begin
            $display("protocol assertions failed %0d times", dut0.u_proto_chk.fail_cnt);
            stop_with_failure();
        end else begin
            $display("All tests passed");
            $finish;
        end
    end

endmodule

/* tests/dual_issue_core_assert.sv */
module dual_issue_core_assert (
    input logic                    clk,
    input logic                    rstn,
    input logic                    issue_valid,
    input logic                    issue_ready,
    input logic                    wb_valid,
    input logic                    wb0_we,
    input core_cfg_pkg::reg_addr_t wb0_rd,
    input logic                    wb1_we,
    input core_cfg_pkg::reg_addr_t wb1_rd
);
    int fail_cnt = 0;
    logic accept;

    assign accept = issue_valid && issue_ready;

    wb_one_cycle: assert property (@(posedge clk) disable iff (!rstn) wb_valid |=> !wb_valid)
        else begin
            $error("wb_valid held longer than one cycle");
            fail_cnt++;
        end

    // busy window runs from the cycle after accept up to wb_valid
    busy_after_accept: assert property (@(posedge clk) disable iff (!rstn)
        accept |=> !issue_ready)
        else begin
            $error("issue_ready high right after accept");
            fail_cnt++;
        end

    busy_until_wb: assert property (@(posedge clk) disable iff (!rstn)
        (!issue_ready && !wb_valid) |=> !issue_ready)
        else begin
            $error("issue_ready rose before wb_valid");
            fail_cnt++;
        end

    busy_at_wb: assert property (@(posedge clk) disable iff (!rstn) wb_valid |-> !issue_ready)
        else begin
            $error("issue_ready high during wb_valid");
            fail_cnt++;
        end

    ready_after_wb: assert property (@(posedge clk) disable iff (!rstn) wb_valid |=> issue_ready)
        else begin
            $error("issue_ready low after wb_valid");
            fail_cnt++;
        end

    no_write_r0: assert property (@(posedge clk) disable iff (!rstn)
        !(wb0_we && wb0_rd == '0) && !(wb1_we && wb1_rd == '0))
        else begin
            $error("write enable set for r0");
            fail_cnt++;
        end

endmodule

bind dual_issue_core dual_issue_core_assert u_proto_chk (
    .clk         (clk),
    .rstn        (rstn),
    .issue_valid (issue_valid),
    .issue_ready (issue_ready),
    .wb_valid    (wb_valid),
    .wb0_we      (wb0_we),
    .wb0_rd      (wb0_rd),
    .wb1_we      (wb1_we),
    .wb1_rd      (wb1_rd)
);

/* hw/dual_issue_core.sv */
module dual_issue_core #(
    parameter int DIV_STEPS = 1
) (
    input  logic                    clk,
    input  logic                    rstn,
    input  logic                    issue_valid,
    input  isa_pkg::opcode_t        op0,
    input  core_cfg_pkg::reg_addr_t rd0,
    input  core_cfg_pkg::reg_addr_t rj0,
    input  core_cfg_pkg::reg_addr_t rk0,
    input  core_cfg_pkg::word_t     imm0,
    input  logic                    use_imm0,
    input  isa_pkg::opcode_t        op1,
    input  core_cfg_pkg::reg_addr_t rd1,
    input  core_cfg_pkg::reg_addr_t rj1,
    input  core_cfg_pkg::reg_addr_t rk1,
    input  core_cfg_pkg::word_t     imm1,
    input  logic                    use_imm1,
    output logic                    issue_ready,
    output logic                    wb_valid,
    output logic                    wb0_we,
    output core_cfg_pkg::reg_addr_t wb0_rd,
    output core_cfg_pkg::word_t     wb0_data,
    output logic                    wb1_we,
    output core_cfg_pkg::reg_addr_t wb1_rd,
    output core_cfg_pkg::word_t     wb1_data
);
    import core_cfg_pkg::*;

    logic start;
    word_t rj0_val;
    word_t rk0_val;
    word_t rj1_val;
    word_t rk1_val;
    word_t opb0;
    word_t opb1;
    logic done0;
    logic done1;
    word_t res0;
    word_t res1;
    reg_addr_t res_rd0;
    reg_addr_t res_rd1;

    // accept also kicks off both lanes
    assign start = issue_valid && issue_ready;
    assign opb0 = use_imm0 ? imm0 : rk0_val;
    assign opb1 = use_imm1 ? imm1 : rk1_val;

    alu_mul_lane u_lane0 (
        .clk       (clk),
        .rstn      (rstn),
        .start     (start),
        .op        (op0),
        .rd        (rd0),
        .a         (rj0_val),
        .b         (opb0),
        .done      (done0),
        .result    (res0),
        .result_rd (res_rd0)
    );

    alu_div_lane #(
        .DIV_STEPS (DIV_STEPS)
    ) u_lane1 (
        .clk       (clk),
        .rstn      (rstn),
        .start     (start),
        .op        (op1),
        .rd        (rd1),
        .a         (rj1_val),
        .b         (opb1),
        .done      (done1),
        .result    (res1),
        .result_rd (res_rd1)
    );

    reg_writeback u_wb (
        .clk         (clk),
        .rstn        (rstn),
        .start       (start),
        .rj0         (rj0),
        .rk0         (rk0),
        .rj1         (rj1),
        .rk1         (rk1),
        .done0       (done0),
        .done1       (done1),
        .res0        (res0),
        .res1        (res1),
        .res_rd0     (res_rd0),
        .res_rd1     (res_rd1),
        .rj0_val     (rj0_val),
        .rk0_val     (rk0_val),
        .rj1_val     (rj1_val),
        .rk1_val     (rk1_val),
        .issue_ready (issue_ready),
        .wb_valid    (wb_valid),
        .wb0_we      (wb0_we),
        .wb0_rd      (wb0_rd),
        .wb0_data    (wb0_data),
        .wb1_we      (wb1_we),
        .wb1_rd      (wb1_rd),
        .wb1_data    (wb1_data)
    );

endmodule

/* hw/reg_writeback.sv */
module reg_writeback (
    input  logic                    clk,
    input  logic                    rstn,
    input  logic                    start,
    input  core_cfg_pkg::reg_addr_t rj0,
    input  core_cfg_pkg::reg_addr_t rk0,
    input  core_cfg_pkg::reg_addr_t rj1,
    input  core_cfg_pkg::reg_addr_t rk1,
    input  logic                    done0,
    input  logic                    done1,
    input  core_cfg_pkg::word_t     res0,
    input  core_cfg_pkg::word_t     res1,
    input  core_cfg_pkg::reg_addr_t res_rd0,
    input  core_cfg_pkg::reg_addr_t res_rd1,
    output core_cfg_pkg::word_t     rj0_val,
    output core_cfg_pkg::word_t     rk0_val,
    output core_cfg_pkg::word_t     rj1_val,
    output core_cfg_pkg::word_t     rk1_val,
    output logic                    issue_ready,
    output logic                    wb_valid,
    output logic                    wb0_we,
    output core_cfg_pkg::reg_addr_t wb0_rd,
    output core_cfg_pkg::word_t     wb0_data,
    output logic                    wb1_we,
    output core_cfg_pkg::reg_addr_t wb1_rd,
    output core_cfg_pkg::word_t     wb1_data
);
    import core_cfg_pkg::*;

    word_t regs [NUM_REGS];
    logic busy;
    logic got0;
    logic got1;
    word_t held_data0;
    word_t held_data1;
    reg_addr_t held_rd0;
    reg_addr_t held_rd1;

    // r0 is never written, so it keeps its reset value
    assign rj0_val = regs[rj0];
    assign rk0_val = regs[rk0];
    assign rj1_val = regs[rj1];
    assign rk1_val = regs[rk1];

    assign issue_ready = !busy;
    assign wb_valid = got0 && got1;
    assign wb0_we = wb_valid && (held_rd0 != '0);
    assign wb1_we = wb_valid && (held_rd1 != '0);
    assign wb0_rd = held_rd0;
    assign wb1_rd = held_rd1;
    assign wb0_data = held_data0;
    assign wb1_data = held_data1;

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            busy <= 1'b0;
            got0 <= 1'b0;
            got1 <= 1'b0;
        end else begin
            if (start) begin
                busy <= 1'b1;
            end else if (wb_valid) begin
                busy <= 1'b0;
            end
            if (wb_valid) begin
                got0 <= 1'b0;
                got1 <= 1'b0;
            end else begin
                got0 <= got0 || done0;
                got1 <= got1 || done1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (done0) begin
            held_data0 <= res0;
            held_rd0   <= res_rd0;
        end
        if (done1) begin
            held_data1 <= res1;
            held_rd1   <= res_rd1;
        end
    end

    // lane 1 written last so it wins on a shared rd
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else begin
            if (wb0_we) begin
                regs[held_rd0] <= held_data0;
            end
            if (wb1_we) begin
                regs[held_rd1] <= held_data1;
            end
        end
    end

endmodule

/* hw/alu_div_lane.sv */
module alu_div_lane #(
    parameter int DIV_STEPS = 1
) (
    input  logic                    clk,
    input  logic                    rstn,
    input  logic                    start,
    input  isa_pkg::opcode_t        op,
    input  core_cfg_pkg::reg_addr_t rd,
    input  core_cfg_pkg::word_t     a,
    input  core_cfg_pkg::word_t     b,
    output logic                    done,
    output core_cfg_pkg::word_t     result,
    output core_cfg_pkg::reg_addr_t result_rd
);
    import core_cfg_pkg::*;
    import isa_pkg::*;

    localparam int NUM_ITER = XLEN / DIV_STEPS;
    localparam int CNT_W = $clog2(NUM_ITER + 1);

    typedef enum logic [1:0] {
        div_idle,
        div_busy,
        div_done
    } div_state_t;

    div_state_t state;
    logic [CNT_W-1:0] iter_cnt;
    logic is_div_op;
    logic is_signed_op;
    word_t mag_a;
    word_t mag_b;
    word_t quo_q;
    word_t rem_q;
    word_t dsr_q;
    word_t dvd_q;
    logic neg_quo_q;
    logic neg_rem_q;
    logic want_rem_q;
    logic by_zero_q;
    word_t quo_nx;
    word_t rem_nx;
    word_t div_res;

    assign is_div_op = op inside {op_div, op_divu, op_mod, op_modu};
    assign is_signed_op = (op == op_div) || (op == op_mod);
    assign mag_a = (is_signed_op && a[XLEN-1]) ? -a : a;
    assign mag_b = (is_signed_op && b[XLEN-1]) ? -b : b;

    // DIV_STEPS restoring steps per cycle
    always_comb begin
        logic [XLEN:0] shifted;
        quo_nx = quo_q;
        rem_nx = rem_q;
        for (int i = 0; i < DIV_STEPS; i++) begin
            shifted = {rem_nx, quo_nx[XLEN-1]};
            quo_nx = {quo_nx[XLEN-2:0], 1'b0};
            if (shifted >= {1'b0, dsr_q}) begin
                shifted = shifted - {1'b0, dsr_q};
                quo_nx[0] = 1'b1;
            end
            rem_nx = shifted[XLEN-1:0];
        end
    end

    // most negative / -1 needs no special case, the magnitude path gives it
    always_comb begin
        if (by_zero_q) begin
            div_res = want_rem_q ? dvd_q : '1;
        end else if (want_rem_q) begin
            div_res = neg_rem_q ? -rem_nx : rem_nx;
        end else begin
            div_res = neg_quo_q ? -quo_nx : quo_nx;
        end
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            state    <= div_idle;
            iter_cnt <= '0;
        end else begin
            case (state)
                div_idle: begin
                    if (start) begin
                        state    <= is_div_op ? div_busy : div_done;
                        iter_cnt <= CNT_W'(NUM_ITER);
                    end
                end
                div_busy: begin
                    iter_cnt <= iter_cnt - 1'b1;
                    if (iter_cnt == CNT_W'(1)) begin
                        state <= div_done;
                    end
                end
                default: state <= div_idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == div_idle && start) begin
            result     <= alu_eval(op, a, b);
            result_rd  <= rd;
            quo_q      <= mag_a;
            rem_q      <= '0;
            dsr_q      <= mag_b;
            dvd_q      <= a;
            neg_quo_q  <= is_signed_op && (a[XLEN-1] ^ b[XLEN-1]);
            neg_rem_q  <= is_signed_op && a[XLEN-1];
            want_rem_q <= (op == op_mod) || (op == op_modu);
            by_zero_q  <= (b == '0);
        end else if (state == div_busy) begin
            quo_q <= quo_nx;
            rem_q <= rem_nx;
            // last pass, fold in signs
            if (iter_cnt == CNT_W'(1)) begin
                result <= div_res;
            end
        end
    end

    assign done = (state == div_done);

endmodule

/* hw/alu_mul_lane.sv */
module alu_mul_lane (
    input  logic                    clk,
    input  logic                    rstn,
    input  logic                    start,
    input  isa_pkg::opcode_t        op,
    input  core_cfg_pkg::reg_addr_t rd,
    input  core_cfg_pkg::word_t     a,
    input  core_cfg_pkg::word_t     b,
    output logic                    done,
    output core_cfg_pkg::word_t     result,
    output core_cfg_pkg::reg_addr_t result_rd
);
    import core_cfg_pkg::*;
    import isa_pkg::*;

    word_t lane_res;

    // only the low half of the product is kept
    always_comb begin
        if (op == op_mul) begin
            lane_res = a * b;
        end else begin
            lane_res = alu_eval(op, a, b);
        end
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            done <= 1'b0;
        end else begin
            done <= start;
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            result    <= lane_res;
            result_rd <= rd;
        end
    end

endmodule

/* hw/isa_pkg.sv */
package isa_pkg;

    import core_cfg_pkg::*;

    typedef enum logic [3:0] {
        op_add,
        op_sub,
        op_and,
        op_or,
        op_xor,
        op_slt,
        op_sltu,
        op_sll,
        op_srl,
        op_sra,
        // lane 0 only
        op_mul,
        // lane 1 only
        op_div,
        op_divu,
        op_mod,
        op_modu
    } opcode_t;

    // shared by both lanes, non-ALU opcodes give zero
    function automatic word_t alu_eval(opcode_t op, word_t a, word_t b);
        logic [$clog2(XLEN)-1:0] shamt;
        shamt = b[$clog2(XLEN)-1:0];
        case (op)
            op_add:  return a + b;
            op_sub:  return a - b;
            op_and:  return a & b;
            op_or:   return a | b;
            op_xor:  return a ^ b;
            op_slt:  return word_t'($signed(a) < $signed(b));
            op_sltu: return word_t'(a < b);
            op_sll:  return a << shamt;
            op_srl:  return a >> shamt;
            op_sra:  return word_t'($signed(a) >>> shamt);
            default: return '0;
        endcase
    endfunction

endpackage

/* hw/core_cfg_pkg.sv */
package core_cfg_pkg;

    // datapath word
    localparam int XLEN = 32;

    // architectural register file, r0 is hardwired to zero
    localparam int REG_ADDR_W = 5;
    localparam int NUM_REGS = 32;

    typedef logic [XLEN-1:0] word_t;
    typedef logic [REG_ADDR_W-1:0] reg_addr_t;

endpackage
